//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int INST_ADDR_W = 6;
	localparam int DATA_ADDR_W = 5;
	localparam int INST_WORDS = 2 ** INST_ADDR_W;
	localparam int DATA_WORDS = 2 ** DATA_ADDR_W;
	localparam int NUM_REGS = 32;

	// Serial line timing
	localparam int CLKS_PER_BIT = 8;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int FRAME_BITS = 10; // Start, 8 data, stop

	typedef logic [31:0] word_t;
	typedef logic [INST_ADDR_W-1:0] inst_addr_t;
	typedef logic [DATA_ADDR_W-1:0] data_addr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [7:0] byte_t;
	typedef logic [5:0] op_t;
	typedef logic [5:0] funct_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(CLKS_PER_BIT - 1);
	localparam bit_cnt_t BIT_HALF = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

	localparam reg_idx_t REG_RA = 5'd31; // Link register

	localparam op_t OP_SPECIAL = 6'b000000;
	localparam op_t OP_ADDI    = 6'b001000;
	localparam op_t OP_ANDI    = 6'b001100;
	localparam op_t OP_ORI     = 6'b001101;
	localparam op_t OP_SLTI    = 6'b001010;
	localparam op_t OP_BEQ     = 6'b000100;
	localparam op_t OP_BNE     = 6'b000101;
	localparam op_t OP_J       = 6'b000010;
	localparam op_t OP_JAL     = 6'b000011;
	localparam op_t OP_LUI     = 6'b001111;
	localparam op_t OP_LW      = 6'b100011;
	localparam op_t OP_SW      = 6'b101011;
	localparam op_t OP_IN      = 6'b011010;
	localparam op_t OP_OUT     = 6'b011011;

	localparam funct_t FUNCT_ADD  = 6'b100000;
	localparam funct_t FUNCT_SUB  = 6'b100010;
	localparam funct_t FUNCT_AND  = 6'b100100;
	localparam funct_t FUNCT_OR   = 6'b100101;
	localparam funct_t FUNCT_NOR  = 6'b100111;
	localparam funct_t FUNCT_SLL  = 6'b000000;
	localparam funct_t FUNCT_SRL  = 6'b000010;
	localparam funct_t FUNCT_SLT  = 6'b101010;
	localparam funct_t FUNCT_JR   = 6'b001000;
	localparam funct_t FUNCT_JALR = 6'b001001;

	typedef enum logic {
		LOAD,
		EXEC
	} mode_t;

endpackage

`default_nettype wire

//--- hdl/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver (
	input  logic           CLK,
	input  logic           reset,
	input  logic           rx,
	output cpu_pkg::byte_t data,
	output logic           valid
);

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} state_t;

	state_t            state;
	logic              rx_meta;
	logic              rx_sync;
	cpu_pkg::bit_cnt_t clk_cnt;
	logic [2:0]        bit_idx;
	cpu_pkg::byte_t    shift;
	logic              bit_tick;

	assign bit_tick = clk_cnt == cpu_pkg::BIT_LAST;

	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state   <= IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid   <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync) state <= START;
				end
				START: begin
					if (clk_cnt == cpu_pkg::BIT_HALF) begin // Middle of start bit
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? IDLE : DATA; // Glitch, not a start
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						if (bit_idx == 3'd7) state <= STOP;
						else bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_tick) begin
						state <= IDLE;
						valid <= rx_sync; // Framing error drops the byte
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == DATA && bit_tick) shift <= {rx_sync, shift[7:1]}; // LSB first
		if (state == STOP && bit_tick && rx_sync) data <= shift;
	end

	a_valid_single: assert property (@(posedge CLK) disable iff (reset) valid |=> !valid);

endmodule

`default_nettype wire

//--- hdl/uart_sender.sv
`timescale 1ns/1ps
`default_nettype none

module uart_sender (
	input  logic           CLK,
	input  logic           reset,
	input  cpu_pkg::byte_t data,
	input  logic           start,
	output logic           tx,
	output logic           ready
);

	logic [cpu_pkg::FRAME_BITS-1:0] frame;
	cpu_pkg::bit_cnt_t              clk_cnt;
	logic [3:0]                     bit_cnt;
	logic                           busy;

	assign tx = frame[0];
	assign ready = !busy;

	always_ff @(posedge CLK) begin
		if (reset) begin
			frame   <= '1; // Line idles high
			clk_cnt <= '0;
			bit_cnt <= '0;
			busy    <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				frame   <= {1'b1, data, 1'b0};
				clk_cnt <= '0;
				bit_cnt <= '0;
				busy    <= 1'b1;
			end
		end else if (clk_cnt == cpu_pkg::BIT_LAST) begin
			clk_cnt <= '0;
			frame   <= {1'b1, frame[cpu_pkg::FRAME_BITS-1:1]};
			if (bit_cnt == 4'(cpu_pkg::FRAME_BITS - 1)) busy <= 1'b0; // Stop bit done
			else bit_cnt <= bit_cnt + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	a_idle_high: assert property (@(posedge CLK) disable iff (reset) ready |-> tx);

endmodule

`default_nettype wire

//--- hdl/inst_loader.sv
`timescale 1ns/1ps
`default_nettype none

module inst_loader (
	input  logic                CLK,
	input  logic                reset,
	input  cpu_pkg::mode_t      mode,
	input  cpu_pkg::byte_t      rx_data,
	input  logic                rx_valid,
	input  logic                restart,
	input  cpu_pkg::inst_addr_t pc,
	output cpu_pkg::word_t      inst,
	output logic [5:0]          load_count
);

	cpu_pkg::word_t      mem [cpu_pkg::INST_WORDS];
	cpu_pkg::inst_addr_t wr_addr;
	logic [1:0]          byte_idx;
	logic                take;

	assign take = mode == cpu_pkg::LOAD && rx_valid;

	always_ff @(posedge CLK) begin
		if (reset || restart) begin
			wr_addr  <= '0;
			byte_idx <= '0;
		end else if (take) begin
			{wr_addr, byte_idx} <= {wr_addr, byte_idx} + 1'b1; // Low lane first
		end
	end

	always_ff @(posedge CLK) begin
		if (take) mem[wr_addr][{byte_idx, 3'b000} +: 8] <= rx_data;
	end

	assign inst = mem[pc];
	assign load_count = {wr_addr[3:0], byte_idx};

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input  logic                CLK,
	input  cpu_pkg::data_addr_t addr,
	input  cpu_pkg::word_t      wdata,
	input  logic                we,
	output cpu_pkg::word_t      rdata
);

	cpu_pkg::word_t mem [cpu_pkg::DATA_WORDS];

	always_ff @(posedge CLK) begin
		if (we) mem[addr] <= wdata;
		rdata <= mem[addr]; // Read-first, like a block RAM
	end

endmodule

`default_nettype wire

//--- hdl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input  logic                CLK,
	input  logic                reset,
	input  logic                sw_w,
	input  logic                sw_e,
	input  cpu_pkg::word_t      inst,
	input  cpu_pkg::byte_t      rx_data,
	input  logic                rx_valid,
	input  logic                tx_ready,
	input  cpu_pkg::word_t      dm_rdata,
	output cpu_pkg::mode_t      mode,
	output logic                restart,
	output cpu_pkg::inst_addr_t pc,
	output cpu_pkg::data_addr_t dm_addr,
	output cpu_pkg::word_t      dm_wdata,
	output logic                dm_we,
	output cpu_pkg::byte_t      tx_data,
	output logic                tx_start
);

	cpu_pkg::word_t      gpr [cpu_pkg::NUM_REGS];
	cpu_pkg::mode_t      mode_next;
	logic                exec;
	logic                stage; // Second cycle of LW
	cpu_pkg::inst_addr_t pc_plus_1;

	cpu_pkg::op_t        opcode;
	cpu_pkg::funct_t     funct;
	cpu_pkg::reg_idx_t   rs;
	cpu_pkg::reg_idx_t   rt;
	cpu_pkg::reg_idx_t   rd;
	logic [4:0]          shamt;
	logic [15:0]         imm16;
	cpu_pkg::word_t      rs_val;
	cpu_pkg::word_t      rt_val;
	cpu_pkg::word_t      imm_sext;
	cpu_pkg::word_t      imm_zext;
	cpu_pkg::word_t      eff_addr;

	logic                is_special;
	logic                is_lw;
	logic                is_jump;
	logic                is_jr;
	logic                branch_taken;
	logic                stall;

	logic                wb_en;
	cpu_pkg::reg_idx_t   wb_idx;
	cpu_pkg::word_t      wb_data;

	assign opcode = inst[31:26];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign shamt  = inst[10:6];
	assign funct  = inst[5:0];
	assign imm16  = inst[15:0];

	assign rs_val   = gpr[rs];
	assign rt_val   = gpr[rt];
	assign imm_sext = {{16{imm16[15]}}, imm16};
	assign imm_zext = {16'b0, imm16};
	assign eff_addr = rs_val + imm_sext;

	assign exec      = mode == cpu_pkg::EXEC;
	assign pc_plus_1 = pc + 1'b1;

	// Switches; west wins
	assign mode_next = sw_w ? cpu_pkg::LOAD : (sw_e ? cpu_pkg::EXEC : mode);
	assign restart   = mode_next != mode;

	assign is_special = opcode == cpu_pkg::OP_SPECIAL;
	assign is_lw      = opcode == cpu_pkg::OP_LW;
	assign is_jump    = opcode == cpu_pkg::OP_J || opcode == cpu_pkg::OP_JAL;
	assign is_jr      = is_special && (funct == cpu_pkg::FUNCT_JR || funct == cpu_pkg::FUNCT_JALR);
	assign branch_taken = (opcode == cpu_pkg::OP_BEQ && rs_val == rt_val) ||
		(opcode == cpu_pkg::OP_BNE && rs_val != rt_val);
	assign stall = (opcode == cpu_pkg::OP_IN && !rx_valid) ||
		(opcode == cpu_pkg::OP_OUT && !tx_ready) ||
		(is_lw && !stage);

	assign dm_addr  = eff_addr[cpu_pkg::DATA_ADDR_W-1:0]; // Truncated
	assign dm_wdata = rt_val;
	assign dm_we    = exec && opcode == cpu_pkg::OP_SW;
	assign tx_data  = rt_val[7:0];
	assign tx_start = exec && opcode == cpu_pkg::OP_OUT;

	always_comb begin
		wb_en   = 1'b1;
		wb_idx  = rt;
		wb_data = '0;
		case (opcode)
			cpu_pkg::OP_SPECIAL: begin
				wb_idx = rd;
				case (funct)
					cpu_pkg::FUNCT_ADD: wb_data = rs_val + rt_val;
					cpu_pkg::FUNCT_SUB: wb_data = rs_val - rt_val;
					cpu_pkg::FUNCT_AND: wb_data = rs_val & rt_val;
					cpu_pkg::FUNCT_OR:  wb_data = rs_val | rt_val;
					cpu_pkg::FUNCT_NOR: wb_data = ~(rs_val | rt_val);
					cpu_pkg::FUNCT_SLL: wb_data = rt_val << shamt;
					cpu_pkg::FUNCT_SRL: wb_data = rt_val >> shamt;
					cpu_pkg::FUNCT_SLT: wb_data = {31'b0, $signed(rs_val) < $signed(rt_val)};
					cpu_pkg::FUNCT_JALR: begin
						wb_idx  = cpu_pkg::REG_RA;
						wb_data = cpu_pkg::word_t'(pc_plus_1);
					end
					default: wb_en = 1'b0; // JR and unknown
				endcase
			end
			cpu_pkg::OP_ADDI: wb_data = rs_val + imm_sext;
			cpu_pkg::OP_ANDI: wb_data = rs_val & imm_zext;
			cpu_pkg::OP_ORI:  wb_data = rs_val | imm_zext;
			cpu_pkg::OP_SLTI: wb_data = {31'b0, $signed(rs_val) < $signed(imm_sext)};
			cpu_pkg::OP_LUI:  wb_data = {imm16, 16'b0};
			cpu_pkg::OP_JAL: begin
				wb_idx  = cpu_pkg::REG_RA;
				wb_data = cpu_pkg::word_t'(pc_plus_1);
			end
			cpu_pkg::OP_LW: begin
				wb_en   = stage;
				wb_data = dm_rdata;
			end
			cpu_pkg::OP_IN: begin
				wb_en   = rx_valid;
				wb_data = {rt_val[31:8], rx_data}; // Upper bits kept
			end
			default: wb_en = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (exec && wb_en) gpr[wb_idx] <= wb_data;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			mode  <= cpu_pkg::LOAD;
			pc    <= '0;
			stage <= 1'b0;
		end else begin
			mode <= mode_next;
			if (restart) begin
				pc    <= '0;
				stage <= 1'b0;
			end else if (exec) begin
				stage <= is_lw && !stage;
				if (is_jump) pc <= inst[cpu_pkg::INST_ADDR_W-1:0];
				else if (is_jr) pc <= cpu_pkg::inst_addr_t'(rs_val);
				else if (branch_taken) pc <= pc + cpu_pkg::inst_addr_t'(imm16); // No delay slot
				else if (!stall) pc <= pc_plus_1;
			end
		end
	end

	// Load stage only while the same LW is still current in EXEC
	a_stage_on_lw: assert property (@(posedge CLK) disable iff (reset)
		stage |-> exec && is_lw);

endmodule

`default_nettype wire

//--- hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic       CLK,
	input  logic       reset,
	input  logic       uart_rx,
	input  logic       sw_w,
	input  logic       sw_e,
	output logic       uart_tx,
	output logic       led_w,
	output logic       led_e,
	output logic [5:0] led_debug
);

	cpu_pkg::mode_t      mode;
	logic                restart;
	cpu_pkg::inst_addr_t pc;
	cpu_pkg::word_t      inst;
	logic [5:0]          load_count;
	cpu_pkg::byte_t      rx_data;
	logic                rx_valid;
	cpu_pkg::byte_t      tx_data;
	logic                tx_start;
	logic                tx_ready;
	cpu_pkg::data_addr_t dm_addr;
	cpu_pkg::word_t      dm_wdata;
	cpu_pkg::word_t      dm_rdata;
	logic                dm_we;

	assign led_w = mode == cpu_pkg::LOAD;
	assign led_e = mode == cpu_pkg::EXEC;
	assign led_debug = (mode == cpu_pkg::LOAD) ? load_count : pc; // Download progress or pc

	cpu_core cpu_core_inst (
		.CLK(CLK), .reset(reset), .sw_w(sw_w), .sw_e(sw_e),
		.inst(inst), .rx_data(rx_data), .rx_valid(rx_valid), .tx_ready(tx_ready),
		.dm_rdata(dm_rdata), .mode(mode), .restart(restart), .pc(pc),
		.dm_addr(dm_addr), .dm_wdata(dm_wdata), .dm_we(dm_we),
		.tx_data(tx_data), .tx_start(tx_start)
	);

	inst_loader inst_loader_inst (
		.CLK(CLK), .reset(reset), .mode(mode), .rx_data(rx_data), .rx_valid(rx_valid),
		.restart(restart), .pc(pc), .inst(inst), .load_count(load_count)
	);

	data_mem data_mem_inst (
		.CLK(CLK), .addr(dm_addr), .wdata(dm_wdata), .we(dm_we), .rdata(dm_rdata)
	);

	uart_receiver uart_receiver_inst (
		.CLK(CLK), .reset(reset), .rx(uart_rx), .data(rx_data), .valid(rx_valid)
	);

	uart_sender uart_sender_inst (
		.CLK(CLK), .reset(reset), .data(tx_data), .start(tx_start),
		.tx(uart_tx), .ready(tx_ready)
	);

endmodule

`default_nettype wire

//--- tests/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Program images and the bytes each one must print on uart_tx
cpu_pkg::word_t echo_prog[$];
cpu_pkg::word_t alu_prog[$];
cpu_pkg::byte_t alu_exp[$];
cpu_pkg::word_t mem_prog[$];
cpu_pkg::byte_t mem_exp[$];
cpu_pkg::word_t flow_prog[$];
cpu_pkg::byte_t flow_exp[$];

function automatic cpu_pkg::word_t r_type(input int rs, input int rt, input int rd,
		input int shamt, input cpu_pkg::funct_t funct);
	return {cpu_pkg::OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
endfunction

function automatic cpu_pkg::word_t i_type(input cpu_pkg::op_t op, input int rs, input int rt,
		input int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic cpu_pkg::word_t j_type(input cpu_pkg::op_t op, input int target);
	return {op, 26'(target)};
endfunction

task automatic build_programs;
	cpu_pkg::word_t out3;
	cpu_pkg::word_t out2;
	out3 = i_type(cpu_pkg::OP_OUT, 0, 3, 0);
	out2 = i_type(cpu_pkg::OP_OUT, 0, 2, 0);
	echo_prog = {i_type(cpu_pkg::OP_IN, 0, 1, 0), i_type(cpu_pkg::OP_OUT, 0, 1, 0),
		j_type(cpu_pkg::OP_J, 0)};
	// r0 cleared, r1 = 0x12345678, r2 = 0xffffff0f
	alu_prog = {i_type(cpu_pkg::OP_LUI, 0, 0, 0), i_type(cpu_pkg::OP_LUI, 0, 1, 'h1234),
		i_type(cpu_pkg::OP_ORI, 1, 1, 'h5678), i_type(cpu_pkg::OP_ADDI, 0, 2, -241),
		r_type(1, 2, 3, 0, cpu_pkg::FUNCT_ADD), out3,
		r_type(1, 2, 3, 0, cpu_pkg::FUNCT_SUB), out3,
		r_type(1, 2, 3, 0, cpu_pkg::FUNCT_AND), out3,
		r_type(1, 2, 3, 0, cpu_pkg::FUNCT_OR), out3,
		r_type(1, 2, 3, 0, cpu_pkg::FUNCT_NOR), out3,
		r_type(0, 1, 3, 3, cpu_pkg::FUNCT_SLL), out3,
		r_type(0, 1, 3, 8, cpu_pkg::FUNCT_SRL), out3,
		r_type(2, 1, 3, 0, cpu_pkg::FUNCT_SLT), out3,
		i_type(cpu_pkg::OP_SLTI, 2, 3, -256), out3, // Sign extended immediate
		i_type(cpu_pkg::OP_ANDI, 2, 3, 'hff35), out3, // Zero extended immediate
		j_type(cpu_pkg::OP_J, 24)};
	alu_exp = {8'h87, 8'h69, 8'h08, 8'h7f, 8'h80, 8'hc0, 8'h56, 8'h01, 8'h00, 8'h05};
	// Last store goes through base r5 = 10 to address 30
	mem_prog = {i_type(cpu_pkg::OP_LUI, 0, 0, 0), i_type(cpu_pkg::OP_ADDI, 0, 5, 10),
		i_type(cpu_pkg::OP_ADDI, 0, 1, 'ha5), i_type(cpu_pkg::OP_SW, 0, 1, 3),
		i_type(cpu_pkg::OP_ADDI, 0, 1, 'h3c), i_type(cpu_pkg::OP_SW, 0, 1, 7),
		i_type(cpu_pkg::OP_ADDI, 0, 1, 'h5a), i_type(cpu_pkg::OP_SW, 0, 1, 12),
		i_type(cpu_pkg::OP_ADDI, 0, 1, 'hc3), i_type(cpu_pkg::OP_SW, 5, 1, 20),
		i_type(cpu_pkg::OP_LW, 5, 2, 20), out2, i_type(cpu_pkg::OP_LW, 0, 2, 12), out2,
		i_type(cpu_pkg::OP_LW, 0, 2, 7), out2, i_type(cpu_pkg::OP_LW, 0, 2, 3), out2,
		j_type(cpu_pkg::OP_J, 18)};
	mem_exp = {8'hc3, 8'h5a, 8'h3c, 8'ha5};
	// Countdown at 2..4, subroutine at 13 called by JAL and by JALR
	flow_prog = {i_type(cpu_pkg::OP_LUI, 0, 0, 0), i_type(cpu_pkg::OP_ADDI, 0, 1, 5),
		i_type(cpu_pkg::OP_OUT, 0, 1, 0), i_type(cpu_pkg::OP_ADDI, 1, 1, -1),
		i_type(cpu_pkg::OP_BNE, 1, 0, -2), i_type(cpu_pkg::OP_ADDI, 0, 2, 'h7e),
		i_type(cpu_pkg::OP_BEQ, 2, 0, 2), j_type(cpu_pkg::OP_JAL, 13),
		i_type(cpu_pkg::OP_ADDI, 0, 4, 13), r_type(4, 0, 31, 0, cpu_pkg::FUNCT_JALR),
		i_type(cpu_pkg::OP_ADDI, 0, 3, 'h55), out3, j_type(cpu_pkg::OP_J, 12),
		out2, r_type(31, 0, 0, 0, cpu_pkg::FUNCT_JR)};
	flow_exp = {8'h05, 8'h04, 8'h03, 8'h02, 8'h01, 8'h7e, 8'h7e, 8'h55};
endtask

`endif

//--- tests/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

	localparam int BIT_CLKS = cpu_pkg::CLKS_PER_BIT;
	localparam int WAIT_LIMIT = 40 * cpu_pkg::CLKS_PER_BIT; // About four frames

	logic       CLK;
	logic       reset;
	logic       uart_rx;
	logic       sw_w;
	logic       sw_e;
	logic       uart_tx;
	logic       led_w;
	logic       led_e;
	logic [5:0] led_debug;

	integer seed;
	int     errors;
	int     tests_run;
	int     tests_failed;

	`include "tb_programs.svh"

	cpu_top cpu_top_inst (
		.CLK(CLK), .reset(reset), .uart_rx(uart_rx), .sw_w(sw_w), .sw_e(sw_e),
		.uart_tx(uart_tx), .led_w(led_w), .led_e(led_e), .led_debug(led_debug)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	a_one_mode: assert property (@(posedge CLK) disable iff (reset) led_w != led_e)
		else begin
			$display("Mode LEDs show both modes or none at %0t", $time);
			errors++;
		end

	a_quiet_in_load: assert property (@(posedge CLK) disable iff (reset) led_w |-> uart_tx)
		else begin
			$display("uart_tx left idle while in LOAD mode at %0t", $time);
			errors++;
		end

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic send_byte(input cpu_pkg::byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge CLK);
			uart_rx = frame[i];
			wait_clocks(BIT_CLKS - 1);
		end
	endtask

	task automatic recv_byte(output cpu_pkg::byte_t b);
		int n;
		n = 0;
		b = '0;
		while (uart_tx && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (uart_tx) begin
			$display("No start bit on uart_tx within %0d cycles", WAIT_LIMIT);
			errors++;
		end else begin
			wait_clocks(BIT_CLKS / 2); // Middle of start bit
			for (int i = 0; i < 8; i++) begin
				wait_clocks(BIT_CLKS);
				b[i] = uart_tx;
			end
			wait_clocks(BIT_CLKS);
			assert (uart_tx) else begin
				$display("Stop bit on uart_tx was low");
				errors++;
			end
		end
	endtask

	task automatic check_byte(input string name, input cpu_pkg::byte_t exp,
			input cpu_pkg::byte_t got);
		assert (got === exp) else begin
			$display("** Error: %s expected %h, actual %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic press_switch(input bit west);
		@(negedge CLK);
		if (west) sw_w = 1'b1;
		else sw_e = 1'b1;
		@(negedge CLK);
		sw_w = 1'b0;
		sw_e = 1'b0;
	endtask

	task automatic load_program(input cpu_pkg::word_t prog[$]);
		foreach (prog[i]) begin
			for (int k = 0; k < 4; k++) send_byte(prog[i][8*k +: 8]); // Low byte first
		end
	endtask

	task automatic expect_bytes(input string name, input cpu_pkg::byte_t exp[$]);
		cpu_pkg::byte_t got;
		foreach (exp[i]) begin
			recv_byte(got);
			check_byte(name, exp[i], got);
		end
	endtask

	// West press from EXEC, fresh download, then run
	task automatic reload_and_run(input string name, input cpu_pkg::word_t prog[$],
			input cpu_pkg::byte_t exp[$]);
		press_switch(1'b1);
		check_byte({name, " led_w"}, 8'h01, 8'(led_w));
		check_byte({name, " load pointer"}, 8'h00, 8'(led_debug));
		load_program(prog);
		press_switch(1'b0);
		expect_bytes(name, exp);
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	initial begin
		int             mark;
		cpu_pkg::byte_t b;
		cpu_pkg::byte_t got;
		seed = 32'h0feaa43a;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		uart_rx = 1'b1;
		sw_w = 1'b0;
		sw_e = 1'b0;
		build_programs();
		wait_clocks(8);
		reset = 1'b0;

		mark = errors;
		for (int i = 0; i < 16; i++) begin
			@(negedge CLK);
			check_byte("reset led_w", 8'h01, 8'(led_w));
			check_byte("reset led_e", 8'h00, 8'(led_e));
			check_byte("reset uart_tx", 8'h01, 8'(uart_tx));
		end
		end_test("reset", mark);

		mark = errors;
		load_program(echo_prog);
		press_switch(1'b0);
		for (int i = 0; i < 8; i++) begin
			b = 8'($random(seed));
			fork
				send_byte(b);
				recv_byte(got);
			join
			check_byte("echo", b, got);
			check_byte("echo led_e", 8'h01, 8'(led_e));
		end
		end_test("echo", mark);

		mark = errors;
		reload_and_run("mode switch and alu", alu_prog, alu_exp);
		end_test("mode switch and alu", mark);

		mark = errors;
		reload_and_run("memory", mem_prog, mem_exp);
		end_test("memory", mark);

		mark = errors;
		reload_and_run("control flow", flow_prog, flow_exp);
		end_test("control flow", mark);

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
hdl/cpu_pkg.sv
hdl/uart_receiver.sv
hdl/uart_sender.sv
hdl/inst_loader.sv
hdl/data_mem.sv
hdl/cpu_core.sv
hdl/cpu_top.sv
tests/tb_cpu_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_cpu_top \
	-f src.f -o tb_cpu_top
./obj_dir/tb_cpu_top | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
